/* Makefile */
# Verilator build for the memory-access unit testbench

TOP = mem_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f filelist.f -o mem_unit_sim

run: compile
	./obj_dir/mem_unit_sim | tee run.log
	grep -qF '*** PASSED ***' run.log

clean:
	rm -rf obj_dir run.log

/* filelist.f */
src/mem_unit_pkg.sv
src/dcache_interface.sv
src/mem_ctrl.sv
src/amo_alu.sv
src/data_ram.sv
src/mem_unit_top.sv
testbench/mem_unit_tb.sv

/* src/amo_alu.sv */
// --------------------------------------------------------------------------
// Atomic ALU, merges the old doubleword with the AMO operand
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module amo_alu import mem_unit_pkg::*; (
    input  cmd_t  cmd_i,
    input  size_t size_i,
    input  be_t   be_i,
    input  data_t old_i,       // Doubleword read from RAM
    input  data_t operand_i,   // Operand already in its lane
    output data_t result_o
);

    logic        word_op;
    logic        hi_lane;
    logic        is_unsigned;
    logic [31:0] old_w;
    logic [31:0] opr_w;
    data_t       a;
    data_t       b;
    data_t       res;
    logic        a_lt_s;
    logic        a_lt_u;

    assign word_op     = (size_i == SIZE_W);
    assign hi_lane     = be_i[4];   // Upper word addressed
    assign is_unsigned = (cmd_i == CMD_MINU) || (cmd_i == CMD_MAXU);

    // Word lane extraction
    assign old_w = hi_lane ? old_i[63:32] : old_i[31:0];
    assign opr_w = hi_lane ? operand_i[63:32] : operand_i[31:0];

    // Extend words so one 64-bit compare serves both sizes
    assign a = word_op ? {{32{old_w[31] & !is_unsigned}}, old_w} : old_i;
    assign b = word_op ? {{32{opr_w[31] & !is_unsigned}}, opr_w} : operand_i;

    assign a_lt_s = $signed(a) < $signed(b);
    assign a_lt_u = a < b;

    always_comb begin
        case (cmd_i)
            CMD_SWAP: res = b;
            CMD_ADD:  res = a + b;
            CMD_XOR:  res = a ^ b;
            CMD_AND:  res = a & b;
            CMD_OR:   res = a | b;
            CMD_MIN:  res = a_lt_s ? a : b;
            CMD_MAX:  res = a_lt_s ? b : a;
            CMD_MINU: res = a_lt_u ? a : b;
            CMD_MAXU: res = a_lt_u ? b : a;
            default:  res = a;   // Keep old value
        endcase
    end

    // Word result in both halves, byte mask picks the lane
    assign result_o = word_op ? {2{res[31:0]}} : res;

endmodule

/* src/data_ram.sv */
// --------------------------------------------------------------------------
// Doubleword data RAM with byte-enable writes and registered read
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module data_ram import mem_unit_pkg::*; #(
    parameter int RAM_AW = 8
) (
    input  logic              clk_i,
    input  logic [RAM_AW-1:0] addr_i,   // Doubleword index
    input  logic              re_i,
    input  logic              we_i,
    input  be_t               be_i,
    input  data_t             wdata_i,
    output data_t             rdata_o   // Valid the cycle after re_i
);

    data_t mem_q [2**RAM_AW];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int i = 0; i < 8; i++) begin
                if (be_i[i]) begin
                    mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
        if (re_i) begin
            rdata_o <= mem_q[addr_i];   // Held until next read
        end
    end

endmodule

/* src/dcache_interface.sv */
// --------------------------------------------------------------------------
// Request decoder and response formatter between the CPU and the data RAM
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module dcache_interface import mem_unit_pkg::*; #(
    parameter addr_t IO_BASE = 40'h4000_0000
) (
    input  instr_t instr_i,      // Memory instruction
    input  addr_t  addr_i,       // Byte address
    input  data_t  data_i,       // Store data / AMO operand
    input  data_t  ram_rdata_i,  // Old doubleword from RAM
    input  logic   sc_fail_i,    // SC outcome from controller
    output cmd_t   cmd_o,
    output size_t  size_o,
    output be_t    be_o,
    output data_t  wdata_o,      // Store data in its lane
    output logic   is_load_o,    // Load or LR
    output logic   is_store_o,   // Store or SC
    output logic   is_amo_o,     // Read-modify-write atomic
    output logic   xcpt_ma_o,
    output logic   io_space_o,
    output data_t  resp_data_o
);

    logic       known;        // Instruction code is valid
    logic       ld_unsigned;  // Zero-extend the result
    logic [5:0] lane_shift;   // Bit offset of the addressed lane
    data_t      lane;

    // ----------------------------------------------------------------------
    // Request decode
    // ----------------------------------------------------------------------
    always_comb begin
        known = 1'b1;
        case (instr_i)
            LD, LW, LWU, LH, LHU, LB, LBU: cmd_o = CMD_LOAD;
            SD, SW, SH, SB:                cmd_o = CMD_STORE;
            AMO_LRW, AMO_LRD:              cmd_o = CMD_LR;
            AMO_SCW, AMO_SCD:              cmd_o = CMD_SC;
            AMO_SWAPW, AMO_SWAPD:          cmd_o = CMD_SWAP;
            AMO_ADDW, AMO_ADDD:            cmd_o = CMD_ADD;
            AMO_XORW, AMO_XORD:            cmd_o = CMD_XOR;
            AMO_ANDW, AMO_ANDD:            cmd_o = CMD_AND;
            AMO_ORW, AMO_ORD:              cmd_o = CMD_OR;
            AMO_MINW, AMO_MIND:            cmd_o = CMD_MIN;
            AMO_MAXW, AMO_MAXD:            cmd_o = CMD_MAX;
            AMO_MINWU, AMO_MINDU:          cmd_o = CMD_MINU;
            AMO_MAXWU, AMO_MAXDU:          cmd_o = CMD_MAXU;
            default: begin
                known = 1'b0;              // Unknown code, no access
                cmd_o = CMD_LOAD;
            end
        endcase
    end

    // Access size, doubleword for everything not narrower
    always_comb begin
        case (instr_i)
            LW, LWU, SW, AMO_LRW, AMO_SCW, AMO_SWAPW, AMO_ADDW, AMO_XORW,
            AMO_ANDW, AMO_ORW, AMO_MINW, AMO_MAXW, AMO_MINWU, AMO_MAXWU:
                size_o = SIZE_W;
            LH, LHU, SH: size_o = SIZE_H;
            LB, LBU, SB: size_o = SIZE_B;
            default:     size_o = SIZE_D;
        endcase
    end

    assign ld_unsigned = (instr_i == LWU) || (instr_i == LHU) || (instr_i == LBU);

    // Class bits for the controller and PMU
    assign is_load_o  = known && (cmd_o == CMD_LOAD || cmd_o == CMD_LR);
    assign is_store_o = known && (cmd_o == CMD_STORE || cmd_o == CMD_SC);
    assign is_amo_o   = known && !is_load_o && !is_store_o;

    // Byte mask and misalignment by size
    always_comb begin
        case (size_o)
            SIZE_B: begin
                be_o      = 8'h01 << addr_i[2:0];
                xcpt_ma_o = 1'b0;
            end
            SIZE_H: begin
                be_o      = 8'h03 << addr_i[2:0];
                xcpt_ma_o = addr_i[0];
            end
            SIZE_W: begin
                be_o      = 8'h0f << addr_i[2:0];
                xcpt_ma_o = |addr_i[1:0];
            end
            default: begin
                be_o      = 8'hff;
                xcpt_ma_o = |addr_i[2:0];
            end
        endcase
    end

    assign io_space_o = (addr_i >= IO_BASE) && (addr_i < IO_END);
    assign lane_shift = {addr_i[2:0], 3'b000};
    assign wdata_o    = data_i << lane_shift;  // Move operand to its lane

    // ----------------------------------------------------------------------
    // Response format
    // ----------------------------------------------------------------------
    assign lane = ram_rdata_i >> lane_shift;

    always_comb begin
        if (cmd_o == CMD_SC) begin
            resp_data_o = {63'd0, sc_fail_i};  // 0 on success
        end else begin
            case (size_o)
                SIZE_B:  resp_data_o = {{56{lane[7] & !ld_unsigned}}, lane[7:0]};
                SIZE_H:  resp_data_o = {{48{lane[15] & !ld_unsigned}}, lane[15:0]};
                SIZE_W:  resp_data_o = {{32{lane[31] & !ld_unsigned}}, lane[31:0]};
                default: resp_data_o = lane;
            endcase
        end
    end

endmodule

/* src/mem_ctrl.sv */
// --------------------------------------------------------------------------
// Memory controller FSM for the req/ack handshake, RAM sequencing and LR/SC
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module mem_ctrl import mem_unit_pkg::*; #(
    parameter int RAM_AW = 8
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              req_i,
    input  addr_t             addr_i,
    input  reg_idx_t          rd_i,
    input  cmd_t              cmd_i,
    input  be_t               be_i,
    input  data_t             wdata_i,       // Aligned store data
    input  data_t             amo_result_i,  // New doubleword for atomics
    input  logic              is_load_i,
    input  logic              is_store_i,
    input  logic              is_amo_i,
    input  logic              xcpt_ma_i,
    input  logic              io_space_i,
    output logic              ack_o,
    output reg_idx_t          resp_rd_o,
    output logic [RAM_AW-1:0] ram_addr_o,
    output logic              ram_re_o,
    output logic              ram_we_o,
    output be_t               ram_be_o,
    output data_t             ram_wdata_o,
    output logic              sc_fail_o,
    output logic              pmu_load_o,    // One-cycle load event
    output logic              pmu_store_o    // One-cycle store event
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        accept;        // Request taken this cycle
    logic        blocked;       // Exception, access suppressed
    logic        resv_valid_q;
    logic [36:0] resv_addr_q;   // Reserved doubleword address
    logic        resv_hit;
    logic        store_we;

    assign accept   = (state_q == S_IDLE) && req_i;
    assign blocked  = xcpt_ma_i || io_space_i;
    assign resv_hit = resv_valid_q && (resv_addr_q == addr_i[39:3]);

    // Stores write on the accept edge, SC only with a matching reservation
    assign store_we = accept && is_store_i && !blocked && (cmd_i != CMD_SC || resv_hit);

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (req_i) begin
                    if (!blocked && (is_load_i || is_amo_i)) begin
                        state_d = S_READ;
                    end else begin
                        state_d = S_ACK;   // Store, SC or exception
                    end
                end
            end
            S_READ:  state_d = is_amo_i ? S_WRITE : S_ACK;
            S_WRITE: state_d = S_ACK;
            S_ACK: begin
                if (!req_i) begin
                    state_d = S_IDLE;      // Requester dropped req
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= S_IDLE;
            ack_o       <= 1'b0;
            pmu_load_o  <= 1'b0;
            pmu_store_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            ack_o       <= (state_q == S_ACK) && req_i;  // Falls with req
            pmu_load_o  <= accept && is_load_i;
            pmu_store_o <= accept && is_store_i;
        end
    end

    // ----------------------------------------------------------------------
    // LR reservation
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resv_valid_q <= 1'b0;
        end else if (accept && !blocked && cmd_i == CMD_LR) begin
            resv_valid_q <= 1'b1;
        end else if (accept && cmd_i == CMD_SC) begin
            resv_valid_q <= 1'b0;   // SC always consumes it
        end else if (ram_we_o && resv_hit) begin
            resv_valid_q <= 1'b0;   // Write to the reserved doubleword
        end
    end

    // Response payload captured at acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            resp_rd_o <= rd_i;
            sc_fail_o <= !resv_hit || blocked;
            if (cmd_i == CMD_LR && !blocked) begin
                resv_addr_q <= addr_i[39:3];
            end
        end
    end

    // RAM control
    assign ram_addr_o  = addr_i[RAM_AW+2:3];
    assign ram_re_o    = (state_q == S_READ);
    assign ram_we_o    = store_we || (state_q == S_WRITE);
    assign ram_be_o    = be_i;
    assign ram_wdata_o = is_amo_i ? amo_result_i : wdata_i;  // Write data mux

endmodule

/* src/mem_unit_pkg.sv */
// --------------------------------------------------------------------------
// Memory-access unit package with widths, opcodes, cache commands and FSM
// --------------------------------------------------------------------------
package mem_unit_pkg;

    // Widths that carry a meaning
    typedef logic [39:0] addr_t;     // Byte address
    typedef logic [63:0] data_t;     // Doubleword / register value
    typedef logic [4:0]  reg_idx_t;  // Destination register
    typedef logic [5:0]  instr_t;    // Memory instruction code
    typedef logic [4:0]  cmd_t;      // Cache command
    typedef logic [1:0]  size_t;     // Access size
    typedef logic [7:0]  be_t;       // Byte enable

    localparam addr_t IO_END = 40'h8000_0000;  // I/O window ends below this

    // ----------------------------------------------------------------------
    // Instruction codes
    // ----------------------------------------------------------------------
    localparam instr_t LD          = 6'd0;
    localparam instr_t LW          = 6'd1;
    localparam instr_t LWU         = 6'd2;
    localparam instr_t LH          = 6'd3;
    localparam instr_t LHU         = 6'd4;
    localparam instr_t LB          = 6'd5;
    localparam instr_t LBU         = 6'd6;
    localparam instr_t SD          = 6'd7;
    localparam instr_t SW          = 6'd8;
    localparam instr_t SH          = 6'd9;
    localparam instr_t SB          = 6'd10;
    localparam instr_t AMO_LRW     = 6'd11;
    localparam instr_t AMO_LRD     = 6'd12;
    localparam instr_t AMO_SCW     = 6'd13;
    localparam instr_t AMO_SCD     = 6'd14;
    localparam instr_t AMO_SWAPW   = 6'd15;
    localparam instr_t AMO_SWAPD   = 6'd16;
    localparam instr_t AMO_ADDW    = 6'd17;
    localparam instr_t AMO_ADDD    = 6'd18;
    localparam instr_t AMO_XORW    = 6'd19;
    localparam instr_t AMO_XORD    = 6'd20;
    localparam instr_t AMO_ANDW    = 6'd21;
    localparam instr_t AMO_ANDD    = 6'd22;
    localparam instr_t AMO_ORW     = 6'd23;
    localparam instr_t AMO_ORD     = 6'd24;
    localparam instr_t AMO_MINW    = 6'd25;
    localparam instr_t AMO_MIND    = 6'd26;
    localparam instr_t AMO_MAXW    = 6'd27;
    localparam instr_t AMO_MAXD    = 6'd28;
    localparam instr_t AMO_MINWU   = 6'd29;
    localparam instr_t AMO_MINDU   = 6'd30;
    localparam instr_t AMO_MAXWU   = 6'd31;
    localparam instr_t AMO_MAXDU   = 6'd32;

    // ----------------------------------------------------------------------
    // Cache commands, same encoding as the core's dcache port
    // ----------------------------------------------------------------------
    localparam cmd_t CMD_LOAD  = 5'b00000;
    localparam cmd_t CMD_STORE = 5'b00001;
    localparam cmd_t CMD_SWAP  = 5'b00100;
    localparam cmd_t CMD_LR    = 5'b00110;
    localparam cmd_t CMD_SC    = 5'b00111;
    localparam cmd_t CMD_ADD   = 5'b01000;
    localparam cmd_t CMD_XOR   = 5'b01001;
    localparam cmd_t CMD_OR    = 5'b01010;
    localparam cmd_t CMD_AND   = 5'b01011;
    localparam cmd_t CMD_MIN   = 5'b01100;
    localparam cmd_t CMD_MAX   = 5'b01101;
    localparam cmd_t CMD_MINU  = 5'b01110;
    localparam cmd_t CMD_MAXU  = 5'b01111;

    localparam size_t SIZE_B = 2'd0;
    localparam size_t SIZE_H = 2'd1;
    localparam size_t SIZE_W = 2'd2;
    localparam size_t SIZE_D = 2'd3;

    typedef enum logic [1:0] {
        S_IDLE,   // Waiting for req
        S_READ,   // RAM read in progress
        S_WRITE,  // AMO write-back
        S_ACK     // Holding ack until req drops
    } ctrl_state_t;

endpackage

/* src/mem_unit_top.sv */
// --------------------------------------------------------------------------
// Memory-access unit top, controller, decoder, atomic ALU and data RAM
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module mem_unit_top import mem_unit_pkg::*; #(
    parameter int    RAM_AW  = 8,
    parameter addr_t IO_BASE = 40'h4000_0000
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     req_i,
    input  instr_t   instr_i,
    input  addr_t    addr_i,
    input  data_t    data_i,
    input  reg_idx_t rd_i,
    output logic     ack_o,
    output data_t    resp_data_o,
    output reg_idx_t resp_rd_o,
    output logic     xcpt_ma_o,
    output logic     io_space_o,
    output logic     is_load_o,
    output logic     is_store_o
);

    // Decoder outputs
    cmd_t              cmd;
    size_t             size;
    be_t               be;
    data_t             wdata;
    logic              dec_load;
    logic              dec_store;
    logic              dec_amo;
    logic              sc_fail;
    data_t             amo_result;
    // RAM port
    logic [RAM_AW-1:0] ram_addr;
    logic              ram_re;
    logic              ram_we;
    be_t               ram_be;
    data_t             ram_wdata;
    data_t             ram_rdata;

    mem_ctrl #(.RAM_AW(RAM_AW)) u_mem_ctrl (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .req_i(req_i), .addr_i(addr_i),
        .rd_i(rd_i), .cmd_i(cmd), .be_i(be), .wdata_i(wdata), .amo_result_i(amo_result),
        .is_load_i(dec_load), .is_store_i(dec_store), .is_amo_i(dec_amo),
        .xcpt_ma_i(xcpt_ma_o), .io_space_i(io_space_o), .ack_o(ack_o),
        .resp_rd_o(resp_rd_o), .ram_addr_o(ram_addr), .ram_re_o(ram_re),
        .ram_we_o(ram_we), .ram_be_o(ram_be), .ram_wdata_o(ram_wdata),
        .sc_fail_o(sc_fail), .pmu_load_o(is_load_o), .pmu_store_o(is_store_o)
    );

    dcache_interface #(.IO_BASE(IO_BASE)) u_dcache_interface (
        .instr_i(instr_i), .addr_i(addr_i), .data_i(data_i), .ram_rdata_i(ram_rdata),
        .sc_fail_i(sc_fail), .cmd_o(cmd), .size_o(size), .be_o(be), .wdata_o(wdata),
        .is_load_o(dec_load), .is_store_o(dec_store), .is_amo_o(dec_amo),
        .xcpt_ma_o(xcpt_ma_o), .io_space_o(io_space_o), .resp_data_o(resp_data_o)
    );

    amo_alu u_amo_alu (
        .cmd_i(cmd), .size_i(size), .be_i(be), .old_i(ram_rdata),
        .operand_i(wdata), .result_o(amo_result)
    );

    data_ram #(.RAM_AW(RAM_AW)) u_data_ram (
        .clk_i(clk_i), .addr_i(ram_addr), .re_i(ram_re), .we_i(ram_we),
        .be_i(ram_be), .wdata_i(ram_wdata), .rdata_o(ram_rdata)
    );

endmodule

/* testbench/mem_unit_tb.sv */
// --------------------------------------------------------------------------
// Testbench for the memory-access unit with reference memory and LR/SC model
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module mem_unit_tb import mem_unit_pkg::*; ();

    localparam addr_t IO_BASE = 40'h4000_0000;
    localparam int    TIMEOUT = 20;   // Cycles per handshake phase

    localparam instr_t LS_OPS [11] = '{LD, LW, LWU, LH, LHU, LB, LBU, SD, SW, SH, SB};
    localparam instr_t RMW_OPS [18] = '{AMO_SWAPW, AMO_SWAPD, AMO_ADDW, AMO_ADDD,
        AMO_XORW, AMO_XORD, AMO_ANDW, AMO_ANDD, AMO_ORW, AMO_ORD, AMO_MINW, AMO_MIND,
        AMO_MAXW, AMO_MAXD, AMO_MINWU, AMO_MINDU, AMO_MAXWU, AMO_MAXDU};
    localparam instr_t MIX_OPS [8] = '{SD, SW, LW, AMO_LRD, AMO_LRW, AMO_SCD, AMO_SCW,
        AMO_ADDD};

    logic        clk;
    logic        arst_n;
    logic        req;
    instr_t      instr;
    addr_t       addr;
    data_t       wdata;
    reg_idx_t    rd;
    logic        ack;
    data_t       resp_data;
    reg_idx_t    resp_rd;
    logic        xcpt_ma;
    logic        io_space;
    logic        is_load;
    logic        is_store;

    data_t       ref_mem [256];     // Mirrors the 256-doubleword RAM
    logic        resv_valid;
    logic [36:0] resv_dw;           // Reserved doubleword address
    logic [31:0] lcg_state;
    int          load_pulses;
    int          store_pulses;
    logic [31:0] rnd;
    instr_t      op;
    addr_t       a;

    mem_unit_top #(.RAM_AW(8), .IO_BASE(IO_BASE)) dut (
        .clk_i(clk), .arst_n_i(arst_n), .req_i(req), .instr_i(instr), .addr_i(addr),
        .data_i(wdata), .rd_i(rd), .ack_o(ack), .resp_data_o(resp_data),
        .resp_rd_o(resp_rd), .xcpt_ma_o(xcpt_ma), .io_space_o(io_space),
        .is_load_o(is_load), .is_store_o(is_store)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // ----------------------------------------------------------------------
    // Failure reporting and reference model helpers
    // ----------------------------------------------------------------------
    task automatic report_mismatch(input string name, input data_t exp, input data_t act);
        $display("ERR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int op_bytes(instr_t o);
        if (o inside {LB, LBU, SB}) return 1;
        if (o inside {LH, LHU, SH}) return 2;
        if (o inside {LW, LWU, SW, AMO_LRW, AMO_SCW, AMO_SWAPW, AMO_ADDW, AMO_XORW,
                      AMO_ANDW, AMO_ORW, AMO_MINW, AMO_MAXW, AMO_MINWU, AMO_MAXWU}) return 4;
        return 8;
    endfunction

    // Random aligned address in the first 16 doublewords
    function automatic addr_t rand_addr(int nbytes);
        logic [31:0] r;
        r = next_rand();
        return 40'(8 * int'(r[27:24]) + (int'(r[22:20]) / nbytes) * nbytes);
    endfunction

    // Addressed lane with sign or zero extension
    function automatic data_t lane_value(data_t dw, addr_t aa, int nbytes, logic sgn);
        data_t v;
        v = dw >> (8 * int'(aa[2:0]));
        case (nbytes)
            1: v = {{56{sgn & v[7]}}, v[7:0]};
            2: v = {{48{sgn & v[15]}}, v[15:0]};
            4: v = {{32{sgn & v[31]}}, v[31:0]};
            default: ;
        endcase
        return v;
    endfunction

    function automatic data_t merge_lane(data_t dw, addr_t aa, int nbytes, data_t val);
        int off;
        off = int'(aa[2:0]);
        for (int i = 0; i < nbytes; i++) begin
            dw[8*(off+i) +: 8] = val[8*i +: 8];
        end
        return dw;
    endfunction

    // New memory value of a read-modify-write from the sign-extended old lane
    function automatic data_t amo_value(instr_t o, data_t x, data_t opr, int nbytes);
        data_t y;
        y = (nbytes == 4) ? {{32{opr[31]}}, opr[31:0]} : opr;
        case (o)
            AMO_SWAPW, AMO_SWAPD: return y;
            AMO_ADDW, AMO_ADDD:   return x + y;
            AMO_XORW, AMO_XORD:   return x ^ y;
            AMO_ANDW, AMO_ANDD:   return x & y;
            AMO_ORW, AMO_ORD:     return x | y;
            AMO_MINW, AMO_MIND:   return ($signed(x) < $signed(y)) ? x : y;
            AMO_MAXW, AMO_MAXD:   return ($signed(x) > $signed(y)) ? x : y;
            AMO_MINWU, AMO_MINDU: return (x < y) ? x : y;
            default:              return (x > y) ? x : y;   // Unsigned max
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Predicts and checks one four-phase transaction
    // ----------------------------------------------------------------------
    task automatic run_txn(input instr_t o, input addr_t aa, input data_t d);
        int          nbytes;
        int          idx;
        int          exp_lat;
        int          exp_ld;
        int          exp_st;
        int          cycles;
        int          hold;
        logic        exp_ma;
        logic        exp_io;
        logic        blocked;
        logic        chk_data;
        logic        hit;
        logic [31:0] r;
        reg_idx_t    rd_sent;
        data_t       old_dw;
        data_t       exp_data;
        if (load_pulses != 0 || store_pulses != 0) begin
            report_failure("PMU event seen outside a transaction");
        end
        r       = next_rand();
        rd_sent = r[4:0];
        hold    = int'(r[9:8]);       // Back-pressure cycles
        nbytes  = op_bytes(o);
        idx     = int'(aa[10:3]);
        exp_ma  = (int'(aa[2:0]) % nbytes) != 0;
        exp_io  = (aa >= IO_BASE) && (aa < 40'h8000_0000);
        blocked = exp_ma || exp_io;
        hit     = resv_valid && (resv_dw == aa[39:3]);
        old_dw  = ref_mem[idx];
        chk_data = !blocked;
        exp_data = lane_value(old_dw, aa, nbytes, !(o inside {LWU, LHU, LBU}));
        exp_ld  = 0;
        exp_st  = 0;
        if (o inside {LD, LW, LWU, LH, LHU, LB, LBU, AMO_LRW, AMO_LRD}) begin
            exp_ld  = 1;
            exp_lat = blocked ? 1 : 2;
            if (!blocked && o inside {AMO_LRW, AMO_LRD}) begin
                resv_valid = 1'b1;
                resv_dw    = aa[39:3];
            end
        end else if (o inside {SD, SW, SH, SB}) begin
            exp_st   = 1;
            exp_lat  = 1;
            chk_data = 1'b0;              // No response data for stores
            if (!blocked) begin
                ref_mem[idx] = merge_lane(old_dw, aa, nbytes, d);
                if (hit) resv_valid = 1'b0;
            end
        end else if (o inside {AMO_SCW, AMO_SCD}) begin
            exp_st   = 1;
            exp_lat  = 1;
            chk_data = 1'b1;
            exp_data = (!blocked && hit) ? 64'd0 : 64'd1;
            if (!blocked && hit) ref_mem[idx] = merge_lane(old_dw, aa, nbytes, d);
            resv_valid = 1'b0;            // SC always consumes it
        end else begin
            exp_lat = blocked ? 1 : 3;
            if (!blocked) begin
                ref_mem[idx] = merge_lane(old_dw, aa, nbytes,
                                          amo_value(o, exp_data, d, nbytes));
                if (hit) resv_valid = 1'b0;
            end
        end

        instr = o;
        addr  = aa;
        wdata = d;
        rd    = rd_sent;
        req   = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!ack && cycles < TIMEOUT);
        if (!ack) report_failure("timeout waiting for ack_o to rise");

        // The first edge counted is the one that accepts the request
        assert (cycles - 1 == exp_lat) else report_mismatch("ack_o latency", 64'(exp_lat),
                                                            64'(cycles - 1));
        assert (resp_rd === rd_sent) else report_mismatch("resp_rd_o", 64'(rd_sent),
                                                          64'(resp_rd));
        assert (xcpt_ma === exp_ma) else report_mismatch("xcpt_ma_o", 64'(exp_ma),
                                                         64'(xcpt_ma));
        assert (io_space === exp_io) else report_mismatch("io_space_o", 64'(exp_io),
                                                          64'(io_space));
        if (chk_data) begin
            assert (resp_data === exp_data) else report_mismatch("resp_data_o", exp_data,
                                                                 resp_data);
        end

        for (int k = 0; k < hold; k++) begin
            @(posedge clk);
            #1;
            assert (ack) else report_failure("ack_o fell while req_i was held high");
        end
        req    = 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (ack && cycles < TIMEOUT);
        if (ack) report_failure("timeout waiting for ack_o to fall");

        assert (load_pulses == exp_ld) else report_mismatch("is_load_o pulses",
                                                            64'(exp_ld), 64'(load_pulses));
        assert (store_pulses == exp_st) else report_mismatch("is_store_o pulses",
                                                             64'(exp_st), 64'(store_pulses));
        load_pulses  = 0;
        store_pulses = 0;
    endtask

    // PMU event counters sampled mid-cycle
    always @(negedge clk) begin
        if (is_load) load_pulses++;
        if (is_store) store_pulses++;
    end

    // ----------------------------------------------------------------------
    // Handshake and PMU protocol
    // ----------------------------------------------------------------------
    assert property (@(posedge clk) !arst_n |-> !ack)
        else report_failure("ack_o high during reset");
    assert property (@(posedge clk) disable iff (!arst_n) !req |=> !$rose(ack))
        else report_failure("ack_o rose while req_i was low");
    assert property (@(posedge clk) disable iff (!arst_n) $fell(ack) |-> !$past(req))
        else report_failure("ack_o fell before req_i fell");
    assert property (@(posedge clk) disable iff (!arst_n) ack && req |=> ack)
        else report_failure("ack_o dropped while req_i stayed high");
    assert property (@(posedge clk) disable iff (!arst_n) is_load |=> !is_load)
        else report_failure("is_load_o longer than one cycle");
    assert property (@(posedge clk) disable iff (!arst_n) is_store |=> !is_store)
        else report_failure("is_store_o longer than one cycle");
    assert property (@(posedge clk) disable iff (!arst_n) !(is_load && is_store))
        else report_failure("is_load_o and is_store_o high together");

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        arst_n = 1'b1;
        req    = 1'b0;
        instr  = LD;
        addr   = '0;
        wdata  = '0;
        rd     = '0;
        lcg_state    = 32'hf42b_e255;
        resv_valid   = 1'b0;
        resv_dw      = '0;
        load_pulses  = 0;
        store_pulses = 0;
        #1 arst_n = 1'b0;               // Edge for the async reset
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
        @(posedge clk);
        #1;

        for (int i = 0; i < 16; i++) begin   // Fill before any read
            run_txn(SD, 40'(8 * i), {next_rand(), next_rand()});
        end

        for (int i = 0; i < 80; i++) begin   // Loads and stores of all sizes
            rnd = next_rand();
            op  = LS_OPS[int'(rnd[30:16]) % 11];
            run_txn(op, rand_addr(op_bytes(op)), {next_rand(), next_rand()});
        end

        for (int i = 0; i < 36; i++) begin   // Every atomic twice with a reload after each
            op = RMW_OPS[i % 18];
            a  = rand_addr(op_bytes(op));
            run_txn(op, a, {next_rand(), next_rand()});
            run_txn(LD, {a[39:3], 3'b000}, '0);
        end

        // Directed LR/SC cases
        run_txn(AMO_LRD, 40'h40, '0);
        run_txn(AMO_SCD, 40'h40, 64'h0123_4567_89ab_cdef);   // Succeeds
        run_txn(AMO_SCD, 40'h40, 64'hdead_beef_dead_beef);   // No reservation
        run_txn(AMO_LRW, 40'h44, '0);
        run_txn(AMO_SCW, 40'h48, 64'h5555_aaaa);             // Other address
        run_txn(AMO_LRD, 40'h50, '0);
        run_txn(SB, 40'h53, 64'h7e);                         // Breaks reservation
        run_txn(AMO_SCD, 40'h50, 64'h1111_2222_3333_4444);
        run_txn(AMO_LRD, 40'h58, '0);
        run_txn(AMO_ADDD, 40'h58, 64'd9);
        run_txn(AMO_SCD, 40'h58, '1);
        run_txn(AMO_LRW, 40'h5c, '0);
        run_txn(AMO_SCW, 40'h5c, 64'h8765_4321);             // Upper word lane
        for (int i = 0; i < 40; i++) begin   // Mixed traffic on two doublewords
            rnd = next_rand();
            op  = MIX_OPS[int'(rnd[18:16])];
            a   = 40'(16 + 8 * int'(rnd[28]) + 4 * int'(rnd[27]) * int'(op_bytes(op) == 4));
            run_txn(op, a, {next_rand(), next_rand()});
        end

        // Misaligned and I/O-window accesses that leave memory untouched
        run_txn(LH, 40'h09, '0);
        run_txn(LW, 40'h1a, '0);
        run_txn(SD, 40'h23, '1);
        run_txn(SW, 40'h2e, '1);
        run_txn(AMO_ADDW, 40'h32, 64'd1);
        run_txn(AMO_LRD, 40'h4c, '0);                        // No reservation set
        run_txn(AMO_SCD, 40'h48, '1);
        run_txn(SD, IO_BASE + 40'h10, '1);
        run_txn(SW, IO_BASE + 40'h18, '1);
        run_txn(LD, IO_BASE + 40'h20, '0);
        run_txn(AMO_SWAPD, IO_BASE + 40'h28, '1);
        run_txn(LD, 40'h7fff_fff8, '0);                      // Last window doubleword
        run_txn(LD, 40'h8000_0008, '0);                      // Just above the window
        run_txn(LD, 40'h3fff_f808, '0);                      // Just below the window
        for (int i = 0; i < 16; i++) begin
            run_txn(LD, 40'(8 * i), '0);
        end

        repeat (3) @(posedge clk);
        #1;
        if (load_pulses == 0 && store_pulses == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            report_failure("PMU event after the last transaction");
        end
    end

endmodule
